// File: stereo_dac_output.f
src/dac_pkg.sv
src/sample_fifo.sv
src/halfband_interp.sv
src/mac_arbiter.sv
src/sigma_delta_mod.sv
src/stereo_dac_output.sv
test/tb_clock_gen.sv
test/tb_stereo_dac_output.sv

// File: test/tb_stereo_dac_output.sv
/*
 * Testbench for the stereo DAC output path. Bit densities are counted
 * once per modulator tick after a settle time. Random DC values stay
 * within half scale, where the modulator error stays under two counts.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_stereo_dac_output;
    import dac_pkg::*;

    localparam int CLK_PERIOD_NS   = 10;
    localparam int SETTLE_TICKS    = 64;
    localparam int WINDOW_TICKS    = 512;
    localparam int RATE_TICKS      = 400;
    localparam int DRAIN_TICKS     = 64;
    localparam int TICKS_PER_INPUT = 4;
    localparam int DENSITY_TOL     = 2;
    localparam int BUFFER_TOL      = 14;
    localparam int DC_LIMIT        = 1 << 16;
    localparam int TOTAL_TICKS     = 4 * (SETTLE_TICKS + WINDOW_TICKS) + RATE_TICKS
                                     + DRAIN_TICKS;
    localparam int MARGIN_TICKS    = 256;
    localparam longint WATCHDOG_NS = longint'(TOTAL_TICKS + MARGIN_TICKS) * OSR_DIV
                                     * CLK_PERIOD_NS;

    logic    clk;
    logic    reset;
    logic    in_valid;
    sample_t in_l;
    sample_t in_r;
    logic    in_ready;
    logic    dac_out_l;
    logic    dac_out_r;
    logic    underrun;

    integer  seed      = 32'hf097ff40;
    int      errors    = 0;
    int      checks    = 0;
    int      phase     = 0;
    int      ticks     = 0;
    int      ones_l    = 0;
    int      ones_r    = 0;
    int      accepts   = 0;
    int      underruns = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    stereo_dac_output u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_l      (in_l),
        .in_r      (in_r),
        .in_ready  (in_ready),
        .dac_out_l (dac_out_l),
        .dac_out_r (dac_out_r),
        .underrun  (underrun)
    );

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int expected_density(input sample_t dc, input int window);
        longint half;
        longint num;
        half = longint'(1) << (SAMPLE_W - 1);
        num  = longint'(window) * (longint'(dc) + half);
        return int'((num + half) / (2 * half));
    endfunction

    function automatic int expected_accept(input int span_ticks);
        return span_ticks / TICKS_PER_INPUT;
    endfunction

    function automatic sample_t random_dc();
        return sample_t'($random(seed) % DC_LIMIT);
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_density(input string name, input sample_t dc, input int window,
                                 input int actual);
        int expected;
        int diff;
        expected = expected_density(dc, window);
        diff     = actual - expected;
        checks   = checks + 1;
        if (diff > DENSITY_TOL || diff < -DENSITY_TOL) begin
            errors = errors + 1;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual,
                               input int tol);
        int diff;
        diff   = actual - expected;
        checks = checks + 1;
        if (diff > tol || diff < -tol) begin
            errors = errors + 1;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Counts bits, transfers and underruns; one tick per OSR_DIV cycles
    always @(negedge clk) begin
        if (reset) begin
            phase = 0;
        end else begin
            if (in_valid && in_ready) begin
                accepts = accepts + 1;
            end
            if (underrun) begin
                underruns = underruns + 1;
            end
            phase = phase + 1;
            if (phase == OSR_DIV) begin
                phase  = 0;
                ticks  = ticks + 1;
                ones_l = ones_l + int'(dac_out_l);
                ones_r = ones_r + int'(dac_out_r);
            end
        end
    end

    // New values only after the pending transfer has completed
    task automatic set_input(input logic valid, input sample_t l, input sample_t r);
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = in_valid && !in_ready;
            @(posedge clk);
        end
        in_valid <= valid;
        in_l     <= l;
        in_r     <= r;
    endtask

    task automatic wait_ticks(input int n);
        int target;
        target = ticks + n;
        while (ticks < target) begin
            @(posedge clk);
        end
    endtask

    task automatic measure_window(output int cnt_l, output int cnt_r, output int cnt_und);
        int start_l;
        int start_r;
        int start_und;
        start_l   = ones_l;
        start_r   = ones_r;
        start_und = underruns;
        wait_ticks(WINDOW_TICKS);
        cnt_l   = ones_l - start_l;
        cnt_r   = ones_r - start_r;
        cnt_und = underruns - start_und;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        sample_t dc_l;
        sample_t dc_r;
        logic    ready_seen;
        int      cnt_l;
        int      cnt_r;
        int      cnt_und;
        int      start_acc;
        int      start_und;
        int      start_tick;

        in_valid = 1'b0;
        in_l     = '0;
        in_r     = '0;

        // Reset state
        @(negedge clk);
        check_flag("reset_dac_out_l", 1'b0, dac_out_l);
        check_flag("reset_dac_out_r", 1'b0, dac_out_r);
        check_flag("reset_underrun", 1'b0, underrun);
        check_flag("reset_in_ready", 1'b0, in_ready);
        wait (!reset);
        ready_seen = 1'b0;
        repeat (2) begin
            @(negedge clk);
            ready_seen = ready_seen | in_ready;
            check_flag("release_dac_out_l", 1'b0, dac_out_l);
            check_flag("release_dac_out_r", 1'b0, dac_out_r);
            check_flag("release_underrun", 1'b0, underrun);
        end
        check_flag("release_in_ready", 1'b1, ready_seen);

        // DC on the left channel only
        dc_l = random_dc();
        set_input(1'b1, dc_l, '0);
        wait_ticks(SETTLE_TICKS);
        measure_window(cnt_l, cnt_r, cnt_und);
        check_density("dc_left", dc_l, WINDOW_TICKS, cnt_l);

        // Different DC per channel, same window
        dc_l = random_dc();
        dc_r = random_dc();
        set_input(1'b1, dc_l, dc_r);
        wait_ticks(SETTLE_TICKS);
        measure_window(cnt_l, cnt_r, cnt_und);
        check_density("indep_left", dc_l, WINDOW_TICKS, cnt_l);
        check_density("indep_right", dc_r, WINDOW_TICKS, cnt_r);

        // Pipeline is full here, so input rate follows the tick rate
        start_acc = accepts;
        start_und = underruns;
        wait_ticks(RATE_TICKS);
        check_count("accept_rate", expected_accept(RATE_TICKS), accepts - start_acc,
                    BUFFER_TOL);
        check_flag("rate_no_underrun", 1'b0, underruns != start_und);

        // Stop input and let the FIFOs drain
        set_input(1'b0, '0, '0);
        start_und  = underruns;
        start_tick = ticks;
        while (underruns == start_und && ticks < start_tick + DRAIN_TICKS) begin
            @(posedge clk);
        end
        check_flag("underrun_after_stop", 1'b1, underruns != start_und);
        wait_ticks(SETTLE_TICKS);
        measure_window(cnt_l, cnt_r, cnt_und);
        check_density("idle_left", '0, WINDOW_TICKS, cnt_l);
        check_density("idle_right", '0, WINDOW_TICKS, cnt_r);
        check_count("idle_underrun_pulses", WINDOW_TICKS, cnt_und, 0);

        // Full scale, both polarities
        set_input(1'b1, FULL_SCALE_POS, FULL_SCALE_NEG);
        wait_ticks(SETTLE_TICKS);
        measure_window(cnt_l, cnt_r, cnt_und);
        check_density("full_scale_pos", FULL_SCALE_POS, WINDOW_TICKS, cnt_l);
        check_density("full_scale_neg", FULL_SCALE_NEG, WINDOW_TICKS, cnt_r);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
/*
 * Testbench clock and reset. Reset is released with a non-blocking
 * update on a rising edge after RESET_CYCLES edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/stereo_dac_output.sv
/*
 * Stereo interpolating sigma-delta DAC output path, 4x oversampled.
 * Input must average no more than one sample per 4*OSR_DIV clocks.
 */
`timescale 1ns/1ps
`default_nettype none

module stereo_dac_output (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  dac_pkg::sample_t in_l,
    input  dac_pkg::sample_t in_r,
    output logic             in_ready,
    output logic             dac_out_l,
    output logic             dac_out_r,
    output logic             underrun
);
    import dac_pkg::*;

    logic                   s1_valid;
    logic                   s1_ready;
    sample_t                s1_l;
    sample_t                s1_r;
    logic                   f12_valid;
    logic                   f12_ready;
    sample_t                f12_l;
    sample_t                f12_r;
    logic                   s2_valid;
    logic                   s2_ready;
    sample_t                s2_l;
    sample_t                s2_r;
    logic                   f2m_valid;
    logic                   f2m_ready;
    sample_t                f2m_l;
    sample_t                f2m_r;

    // MAC ports, index 0 is stage 1
    logic [1:0]             mac_req;
    logic [1:0]             op_valid;
    logic [1:0]             op_ready;
    logic [1:0][SAMPLE_W:0] op_a_l;
    logic [1:0][SAMPLE_W:0] op_a_r;
    coef_t [1:0]            op_coef;
    logic [1:0]             op_last;
    logic [1:0]             res_valid;
    acc_t [1:0]             res_l;
    acc_t [1:0]             res_r;

    halfband_interp u_stage_1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_l      (in_l),
        .in_r      (in_r),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_l     (s1_l),
        .out_r     (s1_r),
        .mac_req   (mac_req[0]),
        .op_valid  (op_valid[0]),
        .op_ready  (op_ready[0]),
        .op_a_l    (op_a_l[0]),
        .op_a_r    (op_a_r[0]),
        .op_coef   (op_coef[0]),
        .op_last   (op_last[0]),
        .res_valid (res_valid[0]),
        .res_l     (res_l[0]),
        .res_r     (res_r[0])
    );

    sample_fifo #(.DEPTH(4)) u_fifo_1_2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_l      (s1_l),
        .in_r      (s1_r),
        .out_valid (f12_valid),
        .out_ready (f12_ready),
        .out_l     (f12_l),
        .out_r     (f12_r)
    );

    halfband_interp u_stage_2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (f12_valid),
        .in_ready  (f12_ready),
        .in_l      (f12_l),
        .in_r      (f12_r),
        .out_valid (s2_valid),
        .out_ready (s2_ready),
        .out_l     (s2_l),
        .out_r     (s2_r),
        .mac_req   (mac_req[1]),
        .op_valid  (op_valid[1]),
        .op_ready  (op_ready[1]),
        .op_a_l    (op_a_l[1]),
        .op_a_r    (op_a_r[1]),
        .op_coef   (op_coef[1]),
        .op_last   (op_last[1]),
        .res_valid (res_valid[1]),
        .res_l     (res_l[1]),
        .res_r     (res_r[1])
    );

    sample_fifo #(.DEPTH(8)) u_fifo_2_mod (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s2_valid),
        .in_ready  (s2_ready),
        .in_l      (s2_l),
        .in_r      (s2_r),
        .out_valid (f2m_valid),
        .out_ready (f2m_ready),
        .out_l     (f2m_l),
        .out_r     (f2m_r)
    );

    mac_arbiter u_mac (
        .clk       (clk),
        .reset     (reset),
        .mac_req   (mac_req),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_a_l    (op_a_l),
        .op_a_r    (op_a_r),
        .op_coef   (op_coef),
        .op_last   (op_last),
        .res_valid (res_valid),
        .res_l     (res_l),
        .res_r     (res_r)
    );

    sigma_delta_mod u_mod (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (f2m_valid),
        .in_ready  (f2m_ready),
        .in_l      (f2m_l),
        .in_r      (f2m_r),
        .dac_out_l (dac_out_l),
        .dac_out_r (dac_out_r),
        .underrun  (underrun)
    );

endmodule

`default_nettype wire

// File: src/sigma_delta_mod.sv
/*
 * Stereo second-order one-bit modulator. Takes one sample per tick of
 * OSR_DIV clocks and uses zero on an empty input, flagging underrun.
 * Integrators clamp, so a full-scale input holds the output at one level.
 */
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_mod (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  dac_pkg::sample_t in_l,
    input  dac_pkg::sample_t in_r,
    output logic             dac_out_l,
    output logic             dac_out_r,
    output logic             underrun
);
    import dac_pkg::*;

    typedef logic signed [SAMPLE_W+5:0] integ_t;
    typedef logic signed [SAMPLE_W+7:0] wide_t;

    logic [$clog2(OSR_DIV)-1:0] tick_cnt;
    logic                       tick;
    sample_t                    x_l;
    sample_t                    x_r;
    integ_t                     i1_l;
    integ_t                     i2_l;
    integ_t                     i1_r;
    integ_t                     i2_r;
    integ_t                     i1_l_nx;
    integ_t                     i2_l_nx;
    integ_t                     i1_r_nx;
    integ_t                     i2_r_nx;

    function automatic integ_t clamp(input wide_t v);
        integ_t lim;
        lim = {1'b0, {(SAMPLE_W+5){1'b1}}};
        if (v > wide_t'(lim)) begin
            return lim;
        end
        if (v < -wide_t'(lim)) begin
            return -lim;
        end
        return integ_t'(v);
    endfunction

    function automatic wide_t fb(input logic bit_val);
        return bit_val ? wide_t'(FULL_SCALE_POS) : wide_t'(FULL_SCALE_NEG);
    endfunction

    assign tick     = (tick_cnt == OSR_DIV - 1);
    assign in_ready = tick;
    assign x_l      = in_valid ? in_l : '0;
    assign x_r      = in_valid ? in_r : '0;

    // Both integrators see the previous output bit
    assign i1_l_nx = clamp(wide_t'(i1_l) + wide_t'(x_l) - fb(dac_out_l));
    assign i2_l_nx = clamp(wide_t'(i2_l) + wide_t'(i1_l_nx) - fb(dac_out_l));
    assign i1_r_nx = clamp(wide_t'(i1_r) + wide_t'(x_r) - fb(dac_out_r));
    assign i2_r_nx = clamp(wide_t'(i2_r) + wide_t'(i1_r_nx) - fb(dac_out_r));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt  <= '0;
            i1_l      <= '0;
            i2_l      <= '0;
            i1_r      <= '0;
            i2_r      <= '0;
            dac_out_l <= 1'b0;
            dac_out_r <= 1'b0;
            underrun  <= 1'b0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            underrun <= tick && !in_valid;
            if (tick) begin
                i1_l      <= i1_l_nx;
                i2_l      <= i2_l_nx;
                i1_r      <= i1_r_nx;
                i2_r      <= i2_r_nx;
                dac_out_l <= !i2_l_nx[SAMPLE_W+5];
                dac_out_r <= !i2_r_nx[SAMPLE_W+5];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mac_arbiter.sv
/*
 * Round-robin arbiter in front of one stereo multiply-accumulate unit.
 * Grant is held for a whole burst; result arrives MAC_LAT cycles after
 * the last op and goes to the requester that issued the burst.
 */
`timescale 1ns/1ps
`default_nettype none

module mac_arbiter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [1:0]                      mac_req,
    input  logic [1:0]                      op_valid,
    output logic [1:0]                      op_ready,
    input  logic [1:0][dac_pkg::SAMPLE_W:0] op_a_l,
    input  logic [1:0][dac_pkg::SAMPLE_W:0] op_a_r,
    input  dac_pkg::coef_t [1:0]            op_coef,
    input  logic [1:0]                      op_last,
    output logic [1:0]                      res_valid,
    output dac_pkg::acc_t [1:0]             res_l,
    output dac_pkg::acc_t [1:0]             res_r
);
    import dac_pkg::*;

    logic grant;
    logic burst_open;
    logic op_fire;
    logic last_fire;
    logic p1_valid;
    logic p1_first;
    logic p1_last;
    logic p1_owner;
    acc_t p1_prod_l;
    acc_t p1_prod_r;
    acc_t acc_l;
    acc_t acc_r;
    logic res_pend;
    logic res_owner;

    assign op_ready  = grant ? 2'b10 : 2'b01;
    assign op_fire   = op_valid[grant];
    assign last_fire = op_fire && op_last[grant];

    assign res_valid = res_pend ? (res_owner ? 2'b10 : 2'b01) : 2'b00;
    assign res_l     = {acc_l, acc_l};
    assign res_r     = {acc_r, acc_r};

    // --------------------------------------------------
    // Grant and pipeline control
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant      <= 1'b0;
            burst_open <= 1'b0;
            p1_valid   <= 1'b0;
            p1_first   <= 1'b0;
            p1_last    <= 1'b0;
            p1_owner   <= 1'b0;
            res_pend   <= 1'b0;
            res_owner  <= 1'b0;
        end else begin
            if (last_fire) begin
                grant      <= !grant;
                burst_open <= 1'b0;
            end else if (op_fire) begin
                burst_open <= 1'b1;
            end else if (!burst_open && !mac_req[grant] && mac_req[!grant]) begin
                grant <= !grant;
            end
            p1_valid  <= op_fire;
            p1_first  <= !burst_open;
            p1_last   <= op_last[grant];
            p1_owner  <= grant;
            res_pend  <= p1_valid && p1_last;
            res_owner <= p1_owner;
        end
    end

    // Multiply, then accumulate
    always_ff @(posedge clk) begin
        p1_prod_l <= acc_t'($signed(op_a_l[grant])) * acc_t'(op_coef[grant]);
        p1_prod_r <= acc_t'($signed(op_a_r[grant])) * acc_t'(op_coef[grant]);
        if (p1_valid) begin
            acc_l <= p1_first ? p1_prod_l : acc_l + p1_prod_l;
            acc_r <= p1_first ? p1_prod_r : acc_r + p1_prod_r;
        end
    end

    // Burst owner keeps the grant and keeps offering ops
    assert property (@(posedge clk) disable iff (reset)
        (burst_open && !last_fire) |=> ($stable(grant) && op_valid[grant]));

    // Result returns to the requester that issued the last op
    assert property (@(posedge clk) disable iff (reset)
        last_fire |-> ##MAC_LAT res_valid[$past(grant, MAC_LAT)]);

endmodule

`default_nettype wire

// File: src/halfband_interp.sv
/*
 * 2x half-band interpolator stage. Emits the centre sample, then the
 * odd-phase sample from one MAC burst of HB_TAPS pre-added pairs.
 * Takes no new input until both outputs have left.
 */
`timescale 1ns/1ps
`default_nettype none

module halfband_interp (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  dac_pkg::sample_t                  in_l,
    input  dac_pkg::sample_t                  in_r,
    output logic                              out_valid,
    input  logic                              out_ready,
    output dac_pkg::sample_t                  out_l,
    output dac_pkg::sample_t                  out_r,
    output logic                              mac_req,
    output logic                              op_valid,
    input  logic                              op_ready,
    output logic signed [dac_pkg::SAMPLE_W:0] op_a_l,
    output logic signed [dac_pkg::SAMPLE_W:0] op_a_r,
    output dac_pkg::coef_t                    op_coef,
    output logic                              op_last,
    input  logic                              res_valid,
    input  dac_pkg::acc_t                     res_l,
    input  dac_pkg::acc_t                     res_r
);
    import dac_pkg::*;

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_EVEN,
        S_OPS,
        S_WAIT,
        S_ODD
    } state_t;

    state_t                     state;
    sample_t                    dl_l [2*HB_TAPS];
    sample_t                    dl_r [2*HB_TAPS];
    logic [$clog2(HB_TAPS)-1:0] op_idx;

    function automatic sample_t round_sat(input acc_t acc);
        acc_t q;
        q = (acc + (acc_t'(1) <<< (COEF_FRAC - 1))) >>> COEF_FRAC;
        if (q > acc_t'(FULL_SCALE_POS)) begin
            return FULL_SCALE_POS;
        end
        if (q < acc_t'(FULL_SCALE_NEG)) begin
            return FULL_SCALE_NEG;
        end
        return sample_t'(q);
    endfunction

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_EVEN) || (state == S_ODD);
    assign mac_req   = (state == S_OPS);
    assign op_valid  = (state == S_OPS);
    assign op_last   = (op_idx == HB_TAPS - 1);
    assign op_coef   = HB_COEF[op_idx];

    // Symmetric pair around the line centre
    assign op_a_l = dl_l[HB_TAPS-1-op_idx] + dl_l[HB_TAPS+op_idx];
    assign op_a_r = dl_r[HB_TAPS-1-op_idx] + dl_r[HB_TAPS+op_idx];

    // --------------------------------------------------
    // Phase sequencer and delay line
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= S_INIT;
            op_idx <= '0;
            for (int k = 0; k < 2*HB_TAPS; k++) begin
                dl_l[k] <= '0;
                dl_r[k] <= '0;
            end
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: begin
                    if (in_valid) begin
                        for (int k = 2*HB_TAPS-1; k > 0; k--) begin
                            dl_l[k] <= dl_l[k-1];
                            dl_r[k] <= dl_r[k-1];
                        end
                        dl_l[0] <= in_l;
                        dl_r[0] <= in_r;
                        state   <= S_EVEN;
                    end
                end
                S_EVEN: begin
                    if (out_ready) begin
                        op_idx <= '0;
                        state  <= S_OPS;
                    end
                end
                S_OPS: begin
                    if (op_ready) begin
                        op_idx <= op_idx + 1'b1;
                        if (op_last) begin
                            state <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (res_valid) begin
                        state <= S_ODD;
                    end
                end
                S_ODD: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Output hold register, loaded per phase
    always_ff @(posedge clk) begin
        if (state == S_IDLE && in_valid) begin
            // d[HB_TAPS-1] moves to the centre tap on this shift
            out_l <= dl_l[HB_TAPS-1];
            out_r <= dl_r[HB_TAPS-1];
        end else if (state == S_WAIT && res_valid) begin
            out_l <= round_sat(res_l);
            out_r <= round_sat(res_r);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        res_valid |-> (state == S_WAIT));

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
/*
 * Stereo sample FIFO, valid/ready on both sides.
 * DEPTH must be a power of two.
 */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  dac_pkg::sample_t in_l,
    input  dac_pkg::sample_t in_r,
    output logic             out_valid,
    input  logic             out_ready,
    output dac_pkg::sample_t out_l,
    output dac_pkg::sample_t out_r
);
    import dac_pkg::*;

    sample_t                  mem_l [DEPTH];
    sample_t                  mem_r [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     wr_en;
    logic                     rd_en;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    // Head of queue straight from the storage registers
    assign out_l = mem_l[rd_ptr];
    assign out_r = mem_r[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_l[wr_ptr] <= in_l;
            mem_r[wr_ptr] <= in_r;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Upstream holds a stalled sample until it is taken
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_l) && $stable(in_r)));

    // Count agrees with the pointer distance
    assert property (@(posedge clk) disable iff (reset)
        (count <= DEPTH) && ((wr_ptr - rd_ptr) == count[$clog2(DEPTH)-1:0]));

endmodule

`default_nettype wire

// File: src/dac_pkg.sv
/*
 * Shared sample, coefficient and accumulator types for the DAC path.
 * HB_COEF sums to 2^(COEF_FRAC-1), so the odd phase has unity DC gain.
 * OSR_DIV fixes the modulator tick; four ticks per input sample.
 */
`default_nettype none

package dac_pkg;

    localparam int SAMPLE_W  = 18;
    localparam int COEF_FRAC = 17;
    localparam int HB_TAPS   = 4;
    localparam int OSR_DIV   = 32;
    localparam int MAC_LAT   = 2;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [17:0]         coef_t;
    typedef logic signed [39:0]         acc_t;

    localparam sample_t FULL_SCALE_POS = sample_t'((1 << (SAMPLE_W - 1)) - 1);
    localparam sample_t FULL_SCALE_NEG = sample_t'(-(1 << (SAMPLE_W - 1)));

    // Pair coefficients, innermost pair first
    localparam coef_t HB_COEF [HB_TAPS] = '{
        coef_t'(80675),
        coef_t'(-20185),
        coef_t'(6488),
        coef_t'(-1442)
    };

endpackage

`default_nettype wire
